// File: src/fb_cfg.svh
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// column index width, 16 columns
`define H_BITS 4

// row index width, 8 rows
`define V_BITS 3

// pixel address is {row, column}
`define ADDR_BITS (`H_BITS + `V_BITS)
`define FB_DEPTH (1 << `ADDR_BITS)

`define COLOR_BITS 4

`endif

// File: src/fb_pkg.sv
`default_nettype none

`include "fb_cfg.svh"

package fb_pkg;

  // one colour code per pixel
  typedef logic [`COLOR_BITS-1:0] pixel_t;

  // four-phase receiver
  typedef enum logic [1:0] {
    ING_IDLE,
    ING_WRITE,
    ING_ACK_HIGH
  } ingest_state_t;

  // dibit serializer
  typedef enum logic [2:0] {
    EXP_IDLE,
    EXP_PRIME,
    EXP_PIXEL_LO,
    EXP_PIXEL_HI,
    EXP_SUM_LO,
    EXP_SUM_HI
  } export_state_t;

endpackage

`default_nettype wire

// File: src/pixel_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

interface pixel_wr_if;

  logic wr_en;
  logic [`ADDR_BITS-1:0] wr_addr;
  fb_pkg::pixel_t wr_data;
  // marks the write of the last pixel of a frame
  logic frame_done;

  modport src (
    output wr_en,
    output wr_addr,
    output wr_data,
    output frame_done
  );

  modport dst (
    input wr_en,
    input wr_addr,
    input wr_data,
    input frame_done
  );

endinterface

`default_nettype wire

// File: src/pixel_ingest.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

module pixel_ingest (
  input wire sys_clk,
  input wire sys_rst,
  input wire pix_req,
  output logic pix_ack,
  input wire [`H_BITS-1:0] pix_col,
  input wire [`V_BITS-1:0] pix_row,
  input wire fb_pkg::pixel_t pix_color,
  input wire pix_last,
  pixel_wr_if.src wr
);

  fb_pkg::ingest_state_t state;
  logic [`ADDR_BITS-1:0] pix_addr;
  logic accept;

  // row shifted past the column bits, plus the column
  assign pix_addr = {pix_row, {`H_BITS{1'b0}}} + {{`V_BITS{1'b0}}, pix_col};

  // ack is always low in idle, so a req seen here is a new one
  assign accept = (state == fb_pkg::ING_IDLE) && pix_req;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= fb_pkg::ING_IDLE;
      pix_ack <= 1'b0;
      wr.wr_en <= 1'b0;
      wr.frame_done <= 1'b0;
    end else begin
      wr.wr_en <= 1'b0;
      wr.frame_done <= 1'b0;
      unique case (state)
        fb_pkg::ING_IDLE: begin
          if (pix_req) begin
            wr.wr_en <= 1'b1;
            wr.frame_done <= pix_last;
            state <= fb_pkg::ING_WRITE;
          end
        end
        fb_pkg::ING_WRITE: begin
          pix_ack <= 1'b1;
          state <= fb_pkg::ING_ACK_HIGH;
        end
        fb_pkg::ING_ACK_HIGH: begin
          // renderer has seen ack and let go of req
          if (!pix_req) begin
            pix_ack <= 1'b0;
            state <= fb_pkg::ING_IDLE;
          end
        end
        default: begin
          pix_ack <= 1'b0;
          state <= fb_pkg::ING_IDLE;
        end
      endcase
    end
  end

  // pixel captured on acceptance, held for the write cycle
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      wr.wr_addr <= pix_addr;
      wr.wr_data <= pix_color;
    end
  end

endmodule

`default_nettype wire

// File: src/frame_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

module frame_store (
  input wire sys_clk,
  input wire sys_rst,
  pixel_wr_if.dst wr,
  input wire [`ADDR_BITS-1:0] rd_addr,
  output fb_pkg::pixel_t rd_data,
  input wire busy,
  output logic [7:0] frame_count
);

  // both halves, first index is the buffer select
  fb_pkg::pixel_t mem [0:1][0:`FB_DEPTH-1];

  logic front_sel;
  logic back_sel;
  logic swap_pending;
  logic do_swap;

  assign back_sel = ~front_sel;

  // swap right away, or on the first idle cycle after the export
  assign do_swap = (wr.frame_done || swap_pending) && !busy;

  // renderer fills the back half
  always_ff @(posedge sys_clk) begin
    if (wr.wr_en) begin
      mem[back_sel][wr.wr_addr] <= wr.wr_data;
    end
  end

  // export reads the front half, one cycle latency
  always_ff @(posedge sys_clk) begin
    rd_data <= mem[front_sel][rd_addr];
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      front_sel <= 1'b0;
      swap_pending <= 1'b0;
      frame_count <= 8'd0;
    end else begin
      if (do_swap) begin
        front_sel <= back_sel;
        swap_pending <= 1'b0;
        // wraps at 256
        frame_count <= frame_count + 8'd1;
      end else if (wr.frame_done) begin
        // export running, hold the frame back
        swap_pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/frame_export.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

module frame_export (
  input wire sys_clk,
  input wire sys_rst,
  input wire trigger,
  output logic [`ADDR_BITS-1:0] rd_addr,
  input wire fb_pkg::pixel_t rd_data,
  output logic busy,
  output logic eth_txen,
  output logic [1:0] eth_txd
);

  localparam logic [`ADDR_BITS-1:0] ADDR_ONE = 1;

  fb_pkg::export_state_t state;
  logic [`ADDR_BITS-1:0] pix_addr;
  fb_pkg::pixel_t checksum;
  logic last_pixel;

  assign last_pixel = &pix_addr;

  // busy covers prime through the last checksum dibit
  assign busy = (state != fb_pkg::EXP_IDLE);
  assign eth_txen = busy && (state != fb_pkg::EXP_PRIME);

  // next pixel is fetched while the high dibit goes out
  assign rd_addr = (state == fb_pkg::EXP_PIXEL_HI) ? pix_addr + ADDR_ONE : pix_addr;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= fb_pkg::EXP_IDLE;
      pix_addr <= '0;
    end else begin
      unique case (state)
        fb_pkg::EXP_IDLE: begin
          if (trigger) begin
            pix_addr <= '0;
            state <= fb_pkg::EXP_PRIME;
          end
        end
        fb_pkg::EXP_PRIME: begin
          state <= fb_pkg::EXP_PIXEL_LO;
        end
        fb_pkg::EXP_PIXEL_LO: begin
          state <= fb_pkg::EXP_PIXEL_HI;
        end
        fb_pkg::EXP_PIXEL_HI: begin
          pix_addr <= pix_addr + ADDR_ONE;
          if (last_pixel) begin
            state <= fb_pkg::EXP_SUM_LO;
          end else begin
            state <= fb_pkg::EXP_PIXEL_LO;
          end
        end
        fb_pkg::EXP_SUM_LO: begin
          state <= fb_pkg::EXP_SUM_HI;
        end
        fb_pkg::EXP_SUM_HI: begin
          state <= fb_pkg::EXP_IDLE;
        end
        default: begin
          state <= fb_pkg::EXP_IDLE;
        end
      endcase
    end
  end

  // running xor, cleared while idle
  always_ff @(posedge sys_clk) begin
    if (state == fb_pkg::EXP_IDLE) begin
      checksum <= '0;
    end else if (state == fb_pkg::EXP_PIXEL_LO) begin
      checksum <= checksum ^ rd_data;
    end
  end

  // low dibit first
  always_comb begin
    unique case (state)
      fb_pkg::EXP_PIXEL_LO: eth_txd = rd_data[1:0];
      fb_pkg::EXP_PIXEL_HI: eth_txd = rd_data[3:2];
      fb_pkg::EXP_SUM_LO: eth_txd = checksum[1:0];
      fb_pkg::EXP_SUM_HI: eth_txd = checksum[3:2];
      default: eth_txd = 2'b00;
    endcase
  end

endmodule

`default_nettype wire

// File: src/frame_pipeline_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

module frame_pipeline_top (
  input wire sys_clk,
  input wire sys_rst,
  input wire pix_req,
  output logic pix_ack,
  input wire [`H_BITS-1:0] pix_col,
  input wire [`V_BITS-1:0] pix_row,
  input wire fb_pkg::pixel_t pix_color,
  input wire pix_last,
  input wire export_trigger,
  output logic eth_txen,
  output logic [1:0] eth_txd,
  output logic [7:0] frame_count
);

  // ingest to store
  pixel_wr_if pix_wr ();

  // store to export
  logic [`ADDR_BITS-1:0] rd_addr;
  fb_pkg::pixel_t rd_data;
  logic busy;

  pixel_ingest pixel_ingest_i (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .pix_req(pix_req),
    .pix_ack(pix_ack),
    .pix_col(pix_col),
    .pix_row(pix_row),
    .pix_color(pix_color),
    .pix_last(pix_last),
    .wr(pix_wr.src)
  );

  frame_store frame_store_i (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .wr(pix_wr.dst),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .busy(busy),
    .frame_count(frame_count)
  );

  frame_export frame_export_i (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .trigger(export_trigger),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .busy(busy),
    .eth_txen(eth_txen),
    .eth_txd(eth_txd)
  );

endmodule

`default_nettype wire

// File: testbench/tb_frame_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

`include "fb_cfg.svh"

module tb_frame_pipeline;

  localparam int STREAM_LEN = 2 * `FB_DEPTH + 2;
  // two frames at 3 cycles a pixel, four exports and the idle waits stay under 2500 cycles
  localparam int TIMEOUT_CYCLES = 10000;

  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef fb_pkg::pixel_t frame_t [0:`FB_DEPTH-1];
  typedef logic [1:0] stream_t [0:STREAM_LEN-1];

  logic sys_clk;
  logic sys_rst;
  logic pix_req;
  logic pix_ack;
  logic [`H_BITS-1:0] pix_col;
  logic [`V_BITS-1:0] pix_row;
  fb_pkg::pixel_t pix_color;
  logic pix_last;
  logic export_trigger;
  logic eth_txen;
  logic [1:0] eth_txd;
  logic [7:0] frame_count;

  frame_t frames [0:1];
  addr_t frame_off [0:1];
  logic [15:0] lfsr = 16'd82;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_base = 0;
  int cycles = 0;

  // handshake monitor state
  logic req_prev = 1'b0;
  logic ack_prev = 1'b0;
  int req_rises = 0;
  int ack_rises = 0;

  // link capture and compare state
  logic txen_prev = 1'b0;
  logic [1:0] cap_q [$];
  int exp_frame_q [$];
  string exp_name_q [$];
  int streams_seen = 0;
  int end_count = 0;

  frame_pipeline_top frame_pipeline_top_i (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .pix_req(pix_req),
    .pix_ack(pix_ack),
    .pix_col(pix_col),
    .pix_row(pix_row),
    .pix_color(pix_color),
    .pix_last(pix_last),
    .export_trigger(export_trigger),
    .eth_txen(eth_txen),
    .eth_txd(eth_txd),
    .frame_count(frame_count)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  // expected link stream: low then high dibit per pixel, then xor checksum
  function automatic void build_stream(input frame_t f, output stream_t s);
    fb_pkg::pixel_t sum;
    sum = '0;
    for (int a = 0; a < `FB_DEPTH; a++) begin
      s[2 * a] = f[a][1:0];
      s[2 * a + 1] = f[a][3:2];
      sum = sum ^ f[a];
    end
    s[STREAM_LEN - 2] = sum[1:0];
    s[STREAM_LEN - 1] = sum[3:2];
  endfunction

  task automatic check(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("Fail %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic tick();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic start_test();
    test_base = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_base);
    end
  endtask

  task automatic make_frame(input int idx);
    logic [15:0] bits;
    for (int a = 0; a < `FB_DEPTH; a++) begin
      take_bits(4, bits);
      frames[idx][a] = bits[3:0];
    end
    take_bits(`ADDR_BITS, bits);
    frame_off[idx] = bits[`ADDR_BITS-1:0];
  endtask

  // four-phase transfer of one pixel
  task automatic send_pixel(input addr_t addr, input fb_pkg::pixel_t color, input logic last);
    pix_col = addr[`H_BITS-1:0];
    pix_row = addr[`ADDR_BITS-1:`H_BITS];
    pix_color = color;
    pix_last = last;
    pix_req = 1'b1;
    tick();
    while (!pix_ack) tick();
    pix_req = 1'b0;
    pix_last = 1'b0;
    tick();
    while (pix_ack) tick();
  endtask

  // odd stride walk gives a shuffled order covering every address
  task automatic send_frame(input int idx, input int first, input int count);
    addr_t addr;
    for (int i = first; i < first + count; i++) begin
      addr = addr_t'(i * 45) + frame_off[idx];
      send_pixel(addr, frames[idx][addr], i == `FB_DEPTH - 1);
    end
  endtask

  task automatic expect_export(input int idx, input string name);
    exp_frame_q.push_back(idx);
    exp_name_q.push_back(name);
  endtask

  task automatic pulse_trigger();
    export_trigger = 1'b1;
    tick();
    export_trigger = 1'b0;
  endtask

  task automatic wait_txen();
    while (!eth_txen) tick();
  endtask

  task automatic wait_streams(input int n);
    while (streams_seen < n) tick();
  endtask

  always @(negedge sys_clk) begin
    if (!sys_rst) begin
      if (pix_req && !req_prev) req_rises++;
      if (pix_ack && !ack_prev) begin
        ack_rises++;
        if (!req_prev) begin
          errors++;
          $display("handshake error: ack rose while req was low");
        end
      end
      if (!pix_ack && ack_prev && req_prev) begin
        errors++;
        $display("handshake error: ack fell while req was still high");
      end
    end
    req_prev = pix_req;
    ack_prev = pix_ack;
  end

  always @(negedge sys_clk) begin : capture_compare
    stream_t exp_s;
    int fidx;
    string tname;
    if (eth_txen) begin
      cap_q.push_back(eth_txd);
    end else if (txen_prev) begin
      end_count = int'(frame_count);
      if (exp_frame_q.size() == 0) begin
        errors++;
        $display("export seen on the link with no export expected");
      end else begin
        fidx = exp_frame_q.pop_front();
        tname = exp_name_q.pop_front();
        build_stream(frames[fidx], exp_s);
        check({tname, " length"}, STREAM_LEN, cap_q.size());
        for (int k = 0; k < STREAM_LEN && k < cap_q.size(); k++) begin
          check($sformatf("%s dibit %0d", tname, k), int'(exp_s[k]), int'(cap_q[k]));
        end
      end
      cap_q.delete();
      streams_seen++;
    end
    txen_prev = eth_txen;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge sys_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    sys_rst = 1'b1;
    pix_req = 1'b0;
    pix_col = '0;
    pix_row = '0;
    pix_color = '0;
    pix_last = 1'b0;
    export_trigger = 1'b0;
    repeat (8) @(posedge sys_clk);
    #1;
    sys_rst = 1'b0;
    tick();

    start_test();
    check("reset pix_ack", 0, int'(pix_ack));
    check("reset eth_txen", 0, int'(eth_txen));
    check("reset eth_txd", 0, int'(eth_txd));
    check("reset frame_count", 0, int'(frame_count));
    finish_test("reset");

    start_test();
    make_frame(0);
    send_frame(0, 0, `FB_DEPTH);
    check("handshake ack count", req_rises, ack_rises);
    finish_test("handshake");

    start_test();
    check("export_a frame_count", 1, int'(frame_count));
    expect_export(0, "export_a");
    pulse_trigger();
    wait_streams(1);
    finish_test("export_a");

    // last pixel of frame b lands while frame a is on the link
    start_test();
    make_frame(1);
    send_frame(1, 0, `FB_DEPTH - 1);
    expect_export(0, "deferred_swap old");
    pulse_trigger();
    wait_txen();
    repeat (40) tick();
    send_frame(1, `FB_DEPTH - 1, 1);
    check("deferred_swap txen at last pixel", 1, int'(eth_txen));
    check("deferred_swap count held", 1, int'(frame_count));
    wait_streams(2);
    check("deferred_swap count at txen fall", 1, end_count);
    repeat (2) tick();
    check("deferred_swap count after", 2, int'(frame_count));
    expect_export(1, "deferred_swap new");
    pulse_trigger();
    wait_streams(3);
    finish_test("deferred_swap");

    start_test();
    expect_export(1, "retrigger");
    pulse_trigger();
    wait_txen();
    repeat (100) tick();
    pulse_trigger();
    wait_streams(4);
    // long enough for a queued second export to run to its end
    repeat (300) tick();
    check("retrigger stream count", 4, streams_seen);
    check("retrigger txen idle", 0, int'(eth_txen));
    finish_test("retrigger");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+src
src/fb_pkg.sv
src/pixel_wr_if.sv
src/pixel_ingest.sv
src/frame_store.sv
src/frame_export.sv
src/frame_pipeline_top.sv
testbench/tb_frame_pipeline.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_frame_pipeline
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed
FAIL_MSG  = Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation gave no result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
